// ==== Makefile ====
SRCS := src.f $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vwb_bus_tb: $(SRCS)
	verilator --binary --timing -j 0 --top-module wb_bus_tb -f src.f

run: obj_dir/Vwb_bus_tb
	@out="$$(./obj_dir/Vwb_bus_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// ==== rtl/wb_bus_consts.svh ====
`ifndef WB_BUS_CONSTS_SVH
`define WB_BUS_CONSTS_SVH

// bus geometry
`define WB_N_SLAVES 3
`define WB_DATA_W 32

// address windows, inclusive
`define WB_S0_BASE 32'h0000_0000
`define WB_S0_HIGH 32'h0000_03FF
`define WB_S1_BASE 32'h0000_1000
`define WB_S1_HIGH 32'h0000_13FF
`define WB_S2_BASE 32'h0000_2000
`define WB_S2_HIGH 32'h0000_2003

// slave sizing and timeout
`define WB_SRAM_WORDS 256
`define WB_TIMEOUT_RESET 16'd16

`endif

// ==== rtl/wb_bus_pkg.sv ====
`default_nettype none

package wb_bus_pkg;

  // decoder FSM states
  typedef enum logic {
    DEC_IDLE = 1'b0,
    DEC_WAIT = 1'b1
  } dec_state_t;

  // encoded index of the selected slave
  typedef logic [1:0] slave_idx_t;

endpackage

`default_nettype wire

// ==== rtl/wb_bus_top.sv ====
`default_nettype none

`include "wb_bus_consts.svh"

module wb_bus_top (
  input  wire                   wb_clk_i,
  input  wire                   wb_rst_i,
  input  wire                   wbm_cyc_i,
  input  wire                   wbm_stb_i,
  input  wire                   wbm_we_i,
  input  wire [3:0]             wbm_sel_i,
  input  wire [31:0]            wbm_adr_i,
  input  wire [`WB_DATA_W-1:0]  wbm_dat_i,
  output logic [`WB_DATA_W-1:0] wbm_dat_o,
  output logic                  wbm_ack_o,
  output logic                  wbm_err_o,
  input  wire                   cfg_we_i,
  input  wire [15:0]            cfg_timeout_i
);

  logic dec_wait;
  logic bus_timeout;

  // one link per slave
  wb_if wbs [`WB_N_SLAVES] ();

  wb_decoder u_decoder (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbm_cyc_i (wbm_cyc_i),
    .wbm_stb_i (wbm_stb_i),
    .wbm_we_i  (wbm_we_i),
    .wbm_sel_i (wbm_sel_i),
    .wbm_adr_i (wbm_adr_i),
    .wbm_dat_i (wbm_dat_i),
    .wbm_dat_o (wbm_dat_o),
    .wbm_ack_o (wbm_ack_o),
    .wbm_err_o (wbm_err_o),
    .timeout_i (bus_timeout),
    .wait_o    (dec_wait),
    .wbs       (wbs)
  );

  wb_timeout_cfg u_timeout (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_timeout_i (cfg_timeout_i),
    .wait_i        (dec_wait),
    .timeout_o     (bus_timeout)
  );

  // sram a at window 0, sram b at window 1
  wb_sram_slave u_sram_a (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .bus      (wbs[0])
  );

  wb_sram_slave u_sram_b (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .bus      (wbs[1])
  );

  wb_delay_slave u_delay (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .bus      (wbs[2])
  );

endmodule

`default_nettype wire

// ==== rtl/wb_decoder.sv ====
`default_nettype none

`include "wb_bus_consts.svh"

module wb_decoder (
  input  wire                   wb_clk_i,
  input  wire                   wb_rst_i,
  input  wire                   wbm_cyc_i,
  input  wire                   wbm_stb_i,
  input  wire                   wbm_we_i,
  input  wire [3:0]             wbm_sel_i,
  input  wire [31:0]            wbm_adr_i,
  input  wire [`WB_DATA_W-1:0]  wbm_dat_i,
  output logic [`WB_DATA_W-1:0] wbm_dat_o,
  output logic                  wbm_ack_o,
  output logic                  wbm_err_o,
  input  wire                   timeout_i,
  output logic                  wait_o,
  wb_if.master                  wbs [`WB_N_SLAVES]
);

  localparam int N = `WB_N_SLAVES;
  localparam logic [31:0] BASE [N] = '{`WB_S0_BASE, `WB_S1_BASE, `WB_S2_BASE};
  localparam logic [31:0] HIGH [N] = '{`WB_S0_HIGH, `WB_S1_HIGH, `WB_S2_HIGH};

  wb_bus_pkg::dec_state_t state_q;
  wb_bus_pkg::slave_idx_t hit_idx;
  wb_bus_pkg::slave_idx_t idx_q;

  logic [N-1:0]          hit;
  logic [N-1:0]          hit_mask;
  logic [N-1:0]          active_q;
  logic [N-1:0]          stb_q;
  logic [N-1:0]          ack_v;
  logic [N-1:0]          err_v;
  logic [`WB_DATA_W-1:0] dat_v [N];
  logic [31:0]           adr_rebased;
  logic [31:0]           adr_q;
  logic                  err_q;

  // highest matching window wins
  function automatic wb_bus_pkg::slave_idx_t encode(input logic [N-1:0] v);
    encode = '0;
    for (int i = 0; i < N; i++) begin
      if (v[i]) begin
        encode = wb_bus_pkg::slave_idx_t'(i);
      end
    end
  endfunction

  for (genvar i = 0; i < N; i++) begin : g_port
    assign hit[i] = (wbm_adr_i >= BASE[i]) && (wbm_adr_i <= HIGH[i]);

    assign wbs[i].cyc   = stb_q[i];
    assign wbs[i].stb   = stb_q[i];
    assign wbs[i].we    = wbm_we_i;
    assign wbs[i].sel   = wbm_sel_i;
    assign wbs[i].adr   = adr_q;
    assign wbs[i].dat_w = wbm_dat_i;

    assign ack_v[i] = wbs[i].ack;
    assign err_v[i] = wbs[i].err;
    assign dat_v[i] = wbs[i].dat_r;
  end

  assign hit_idx     = encode(hit);
  assign adr_rebased = wbm_adr_i - BASE[hit_idx];

  always_comb begin
    hit_mask = '0;
    hit_mask[hit_idx] = 1'b1;
  end

  // return path, masked so a stale ack is dropped
  assign wbm_ack_o = |(ack_v & active_q);
  assign wbm_err_o = err_q | (|(err_v & active_q));
  assign wbm_dat_o = dat_v[idx_q];
  assign wait_o    = (state_q == wb_bus_pkg::DEC_WAIT);

  always_ff @(posedge wb_clk_i) begin
    // one-cycle strobes by default
    stb_q <= '0;
    err_q <= 1'b0;
    if (wb_rst_i) begin
      state_q  <= wb_bus_pkg::DEC_IDLE;
      active_q <= '0;
      idx_q    <= '0;
    end else begin
      case (state_q)
        wb_bus_pkg::DEC_IDLE: begin
          // err_q blocks a second err while the master still holds the request
          if (wbm_cyc_i && wbm_stb_i && !err_q) begin
            if (hit == '0) begin
              err_q <= 1'b1;
            end else begin
              active_q <= hit_mask;
              stb_q    <= hit_mask;
              adr_q    <= adr_rebased;
              idx_q    <= hit_idx;
              state_q  <= wb_bus_pkg::DEC_WAIT;
            end
          end
        end
        wb_bus_pkg::DEC_WAIT: begin
          if (|((ack_v | err_v) & active_q)) begin
            active_q <= '0;
            state_q  <= wb_bus_pkg::DEC_IDLE;
          end else if (timeout_i) begin
            err_q    <= 1'b1;
            active_q <= '0;
            state_q  <= wb_bus_pkg::DEC_IDLE;
          end
        end
        default: begin
          state_q <= wb_bus_pkg::DEC_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/wb_delay_slave.sv ====
`default_nettype none

`include "wb_bus_consts.svh"

module wb_delay_slave (
  input  wire  wb_clk_i,
  input  wire  wb_rst_i,
  wb_if.slave  bus
);

  logic [7:0] lat_q;
  logic [7:0] cnt_q;
  logic       busy_q;
  logic       ack_q;
  logic       req;

  // strobes are ignored while a read is counting
  assign req = bus.cyc & bus.stb & ~busy_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      lat_q  <= 8'd0;
      cnt_q  <= 8'd0;
      busy_q <= 1'b0;
      ack_q  <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      if (busy_q) begin
        if (cnt_q == 8'd1) begin
          ack_q  <= 1'b1;
          busy_q <= 1'b0;
        end
        cnt_q <= cnt_q - 8'd1;
      end else if (req) begin
        if (bus.we) begin
          lat_q <= bus.dat_w[7:0];
          ack_q <= 1'b1;
        end else if (lat_q == 8'd0) begin
          // zero latency behaves like a plain register
          ack_q <= 1'b1;
        end else begin
          cnt_q  <= lat_q;
          busy_q <= 1'b1;
        end
      end
    end
  end

  assign bus.dat_r = {{(`WB_DATA_W-8){1'b0}}, lat_q};
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;

endmodule

`default_nettype wire

// ==== rtl/wb_if.sv ====
`default_nettype none

`include "wb_bus_consts.svh"

interface wb_if;

  // request side, from the decoder
  logic                   cyc;
  logic                   stb;
  logic                   we;
  logic [3:0]             sel;
  logic [31:0]            adr;
  logic [`WB_DATA_W-1:0]  dat_w;

  // response side, from the slave
  logic [`WB_DATA_W-1:0]  dat_r;
  logic                   ack;
  logic                   err;

  modport master (
    output cyc, stb, we, sel, adr, dat_w,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, sel, adr, dat_w,
    output dat_r, ack, err
  );

endinterface

`default_nettype wire

// ==== rtl/wb_sram_slave.sv ====
`default_nettype none

`include "wb_bus_consts.svh"

module wb_sram_slave (
  input  wire  wb_clk_i,
  input  wire  wb_rst_i,
  wb_if.slave  bus
);

  localparam int AW = $clog2(`WB_SRAM_WORDS);

  logic [`WB_DATA_W-1:0] mem [`WB_SRAM_WORDS];
  logic [`WB_DATA_W-1:0] dat_q;
  logic [AW-1:0]         word;
  logic                  req;
  logic                  ack_q;

  // byte address to word index
  assign word = bus.adr[AW+1:2];
  assign req  = bus.cyc & bus.stb;

  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      if (bus.we) begin
        for (int b = 0; b < 4; b++) begin
          if (bus.sel[b]) begin
            mem[word][8*b +: 8] <= bus.dat_w[8*b +: 8];
          end
        end
      end
      dat_q <= mem[word];
    end
  end

  // single-cycle ack for reads and writes
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  assign bus.dat_r = dat_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;

endmodule

`default_nettype wire

// ==== rtl/wb_timeout_cfg.sv ====
`default_nettype none

`include "wb_bus_consts.svh"

module wb_timeout_cfg (
  input  wire        wb_clk_i,
  input  wire        wb_rst_i,
  input  wire        cfg_we_i,
  input  wire [15:0] cfg_timeout_i,
  input  wire        wait_i,
  output logic       timeout_o
);

  logic [15:0] limit_q;
  logic [15:0] count_q;

  // programmable limit
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      limit_q <= `WB_TIMEOUT_RESET;
    end else if (cfg_we_i) begin
      limit_q <= cfg_timeout_i;
    end
  end

  // wait counter, held at zero while the decoder is idle
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      count_q <= '0;
    end else if (!wait_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 16'd1;
    end
  end

  // fires once the wait reaches the limit
  assign timeout_o = wait_i && (count_q == limit_q);

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/wb_bus_pkg.sv
rtl/wb_if.sv
rtl/wb_decoder.sv
rtl/wb_timeout_cfg.sv
rtl/wb_sram_slave.sv
rtl/wb_delay_slave.sv
rtl/wb_bus_top.sv
tests/tb_clock.sv
tests/wb_bus_tb.sv

// ==== tests/tb_clock.sv ====
`default_nettype none

module tb_clock (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // 8 ns period
  initial clk_o = 1'b0;
  always #4 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== tests/wb_bus_tb.sv ====
`default_nettype none

`include "wb_bus_consts.svh"

module wb_bus_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_ROWS     = 17;
  localparam int MAX_CYCLES = N_ROWS * 80;

  typedef struct packed {
    logic        cfg_we;
    logic [15:0] limit;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic [31:0] exp_dat;
    logic        exp_ack;
  } row_t;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic        wbm_cyc_i;
  logic        wbm_stb_i;
  logic        wbm_we_i;
  logic [3:0]  wbm_sel_i;
  logic [31:0] wbm_adr_i;
  logic [31:0] wbm_dat_i;
  logic [31:0] wbm_dat_o;
  logic        wbm_ack_o;
  logic        wbm_err_o;
  logic        cfg_we_i;
  logic [15:0] cfg_timeout_i;

  row_t        rows [N_ROWS];
  logic [31:0] rng;
  int unsigned cycle_cnt = 0;

  tb_clock u_clock (
    .clk_o (wb_clk_i)
  );

  wb_bus_top wb_bus_top_i (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wbm_cyc_i     (wbm_cyc_i),
    .wbm_stb_i     (wbm_stb_i),
    .wbm_we_i      (wbm_we_i),
    .wbm_sel_i     (wbm_sel_i),
    .wbm_adr_i     (wbm_adr_i),
    .wbm_dat_i     (wbm_dat_i),
    .wbm_dat_o     (wbm_dat_o),
    .wbm_ack_o     (wbm_ack_o),
    .wbm_err_o     (wbm_err_o),
    .cfg_we_i      (cfg_we_i),
    .cfg_timeout_i (cfg_timeout_i)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // bytes enabled by sel come from the new word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
    logic [31:0] m;
    m = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        m[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return m;
  endfunction

  // cycles from request edge to response and 0 where the latency is programmable
  function automatic int expected_latency(input logic [31:0] adr);
    if (adr <= `WB_S0_HIGH || (adr >= `WB_S1_BASE && adr <= `WB_S1_HIGH)) begin
      return 2;
    end else if (adr >= `WB_S2_BASE && adr <= `WB_S2_HIGH) begin
      return 0;
    end
    return 1;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic set_row(input int i, input logic cfg_we, input logic [15:0] limit,
                         input logic we, input logic [31:0] adr, input logic [31:0] dat,
                         input logic [3:0] sel, input logic [31:0] exp_dat,
                         input logic exp_ack);
    rows[i] = '{cfg_we, limit, we, adr, dat, sel, exp_dat, exp_ack};
  endtask

  task automatic build_table();
    logic [31:0] d [5];
    logic [7:0]  off_a;
    logic [7:0]  off_b;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] b1;
    for (int k = 0; k < 5; k++) begin
      rng  = xorshift32(rng);
      d[k] = rng;
    end
    rng   = xorshift32(rng);
    off_a = rng[7:0];
    // second offset always differs from the first
    off_b = off_a ^ 8'h80;
    a0    = `WB_S0_BASE + {22'd0, off_a, 2'b00};
    a1    = `WB_S1_BASE + {22'd0, off_a, 2'b00};
    b1    = `WB_S1_BASE + {22'd0, off_b, 2'b00};
    // same offset in both SRAMs and then a partial overwrite of SRAM A
    set_row(0, 1'b0, 16'd0, 1'b1, a0, d[0], 4'hF, 32'd0, 1'b1);
    set_row(1, 1'b0, 16'd0, 1'b1, a1, d[1], 4'hF, 32'd0, 1'b1);
    set_row(2, 1'b0, 16'd0, 1'b1, a0, d[2], 4'b0101, 32'd0, 1'b1);
    set_row(3, 1'b0, 16'd0, 1'b0, a0, 32'd0, 4'hF, merge_bytes(d[0], d[2], 4'b0101), 1'b1);
    set_row(4, 1'b0, 16'd0, 1'b0, a1, 32'd0, 4'hF, d[1], 1'b1);
    set_row(5, 1'b0, 16'd0, 1'b1, b1, d[3], 4'hF, 32'd0, 1'b1);
    set_row(6, 1'b0, 16'd0, 1'b1, b1, d[4], 4'b1100, 32'd0, 1'b1);
    set_row(7, 1'b0, 16'd0, 1'b0, b1, 32'd0, 4'hF, merge_bytes(d[3], d[4], 4'b1100), 1'b1);
    // unmapped holes
    set_row(8, 1'b0, 16'd0, 1'b0, 32'h0000_0800, 32'd0, 4'hF, 32'd0, 1'b0);
    set_row(9, 1'b0, 16'd0, 1'b1, 32'h0000_3000, d[0], 4'hF, 32'd0, 1'b0);
    // delay slave with L=3 under the reset limit of 16
    set_row(10, 1'b0, 16'd0, 1'b1, `WB_S2_BASE, 32'd3, 4'hF, 32'd0, 1'b1);
    set_row(11, 1'b0, 16'd0, 1'b0, `WB_S2_BASE, 32'd0, 4'hF, 32'd3, 1'b1);
    // L=40 overruns T=16
    set_row(12, 1'b0, 16'd0, 1'b1, `WB_S2_BASE, 32'd40, 4'hF, 32'd0, 1'b1);
    set_row(13, 1'b0, 16'd0, 1'b0, `WB_S2_BASE, 32'd0, 4'hF, 32'd0, 1'b0);
    set_row(14, 1'b0, 16'd0, 1'b0, a0, 32'd0, 4'hF, merge_bytes(d[0], d[2], 4'b0101), 1'b1);
    // raised limit lets the same read complete
    set_row(15, 1'b1, 16'd64, 1'b0, `WB_S2_BASE, 32'd0, 4'hF, 32'd40, 1'b1);
    set_row(16, 1'b0, 16'd0, 1'b0, b1, 32'd0, 4'hF, merge_bytes(d[3], d[4], 4'b1100), 1'b1);
  endtask

  task automatic run_row(input int r);
    int          cycles;
    int          lat;
    logic        got_ack;
    logic        got_err;
    logic [31:0] got_dat;
    if (rows[r].cfg_we) begin
      @(posedge wb_clk_i);
      cfg_we_i      <= 1'b1;
      cfg_timeout_i <= rows[r].limit;
    end
    @(posedge wb_clk_i);
    cfg_we_i  <= 1'b0;
    wbm_cyc_i <= 1'b1;
    wbm_stb_i <= 1'b1;
    wbm_we_i  <= rows[r].we;
    wbm_adr_i <= rows[r].adr;
    wbm_dat_i <= rows[r].dat;
    wbm_sel_i <= rows[r].sel;
    cycles  = 0;
    got_ack = 1'b0;
    got_err = 1'b0;
    got_dat = '0;
    // the decoder only samples the request on the following edge
    @(negedge wb_clk_i);
    check("wbm_ack_o", 32'(wbm_ack_o), 32'd0);
    check("wbm_err_o", 32'(wbm_err_o), 32'd0);
    // hold the request until ack or err
    while (!got_ack && !got_err) begin
      @(negedge wb_clk_i);
      cycles++;
      got_ack = wbm_ack_o;
      got_err = wbm_err_o;
      got_dat = wbm_dat_o;
    end
    check("wbm_ack_o", 32'(got_ack), 32'(rows[r].exp_ack));
    check("wbm_err_o", 32'(got_err), 32'(!rows[r].exp_ack));
    lat = expected_latency(rows[r].adr);
    if (lat != 0) begin
      check("response latency", 32'(cycles), 32'(lat));
    end
    if (!rows[r].we && rows[r].exp_ack) begin
      check("wbm_dat_o", got_dat, rows[r].exp_dat);
    end
    @(posedge wb_clk_i);
    wbm_cyc_i <= 1'b0;
    wbm_stb_i <= 1'b0;
    // a late ack from an abandoned slave must not reach the master
    if (got_err) begin
      repeat (50) begin
        @(negedge wb_clk_i);
        check("wbm_ack_o", 32'(wbm_ack_o), 32'd0);
      end
    end
  endtask

  always @(posedge wb_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("run did not finish within %0d cycles", MAX_CYCLES);
      $display("sim failed");
      $fatal(1);
    end
  end

  initial begin
    rng           = 32'd31;
    wb_rst_i      = 1'b1;
    wbm_cyc_i     = 1'b0;
    wbm_stb_i     = 1'b0;
    wbm_we_i      = 1'b0;
    wbm_sel_i     = 4'h0;
    wbm_adr_i     = 32'd0;
    wbm_dat_i     = 32'd0;
    cfg_we_i      = 1'b0;
    cfg_timeout_i = 16'd0;
    build_table();
    repeat (5) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    for (int r = 0; r < N_ROWS; r++) begin
      run_row(r);
    end
    repeat (2) @(posedge wb_clk_i);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
